/* hw/lc3b_isa_pkg.sv */
`default_nettype none

package lc3b_isa_pkg;

	localparam int OPC_WIDTH = 4; // opcode field, inst[15:12]

	typedef logic [15:0] lc3b_word; // pc, target and instruction width

	// encodings follow the LC-3b opcode map
	typedef enum logic [OPC_WIDTH-1:0] {
		OP_BR   = 4'b0000,
		OP_ADD  = 4'b0001,
		OP_LDB  = 4'b0010,
		OP_STB  = 4'b0011,
		OP_JSR  = 4'b0100, // also jsrr
		OP_AND  = 4'b0101,
		OP_LDR  = 4'b0110,
		OP_STR  = 4'b0111,
		OP_RTI  = 4'b1000,
		OP_NOT  = 4'b1001,
		OP_LDI  = 4'b1010,
		OP_STI  = 4'b1011,
		OP_JMP  = 4'b1100, // also ret
		OP_SHF  = 4'b1101,
		OP_LEA  = 4'b1110,
		OP_TRAP = 4'b1111
	} lc3b_opcode_e;

	// opcodes that may change the fetch path
	function automatic logic is_ctrl_flow(lc3b_opcode_e opc);
		case (opc)
			OP_BR, OP_JMP, OP_JSR, OP_TRAP, OP_RTI: begin
				return 1'b1;
			end
			default: begin
				return 1'b0; // alu and memory ops fall through
			end
		endcase
	endfunction

endpackage : lc3b_isa_pkg

`default_nettype wire

/* hw/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// first fetch after reset
	localparam lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000;

	// direct mapped btb geometry
	localparam int BTB_ENTRIES = 16;
	localparam int BTB_INDEX_W = 4;  // pc[4:1], halfword aligned
	localparam int BTB_TAG_W   = 11; // pc[15:5]

	// fetch control states
	typedef enum logic [1:0] {
		F_REQ  = 2'd0, // request on the bus
		F_WAIT = 2'd1, // one read in flight
		F_DROP = 2'd2  // in flight read went stale on flush
	} fetch_state_e;

endpackage : fetch_pkg

`default_nettype wire

/* hw/btb.sv */
`timescale 1ns/1ps
`default_nettype none

module btb (
	input  logic                    clk,
	input  logic                    rst_n,

	// lookup side, from fetch
	input  lc3b_isa_pkg::lc3b_word  lookup_pc,
	output logic                    hit,
	output logic                    pred_taken,
	output lc3b_isa_pkg::lc3b_word  pred_target,

	// training side, from execute
	input  logic                    upd_valid,
	input  lc3b_isa_pkg::lc3b_word  upd_pc,
	input  lc3b_isa_pkg::lc3b_word  upd_target,
	input  logic                    upd_taken
);

	localparam int N  = fetch_pkg::BTB_ENTRIES;
	localparam int IW = fetch_pkg::BTB_INDEX_W;
	localparam int TW = fetch_pkg::BTB_TAG_W;

	logic [N-1:0]           valid_q;      // entry valid bits
	logic [N-1:0]           taken_q;      // last outcome per entry
	logic [TW-1:0]          tag_q [N];    // upper pc bits
	lc3b_isa_pkg::lc3b_word target_q [N]; // branch target

	logic [IW-1:0] rd_idx;
	logic [TW-1:0] rd_tag;
	logic [IW-1:0] wr_idx;
	logic [TW-1:0] wr_tag;

	// index skips bit 0, instructions are word aligned
	assign rd_idx = lookup_pc[IW:1];
	assign rd_tag = lookup_pc[15 -: TW];
	assign wr_idx = upd_pc[IW:1];
	assign wr_tag = upd_pc[15 -: TW];

	// combinational read, same cycle as the pc
	assign hit         = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
	assign pred_taken  = taken_q[rd_idx];  // qualified by hit in fetch
	assign pred_target = target_q[rd_idx];

	// valid bits, all entries empty out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (upd_valid) begin
			valid_q[wr_idx] <= 1'b1; // allocate or overwrite
		end
	end

	// entry payload, replaces whatever sat at the index
	always_ff @(posedge clk) begin
		if (upd_valid) begin
			tag_q[wr_idx]    <= wr_tag;
			target_q[wr_idx] <= upd_target;
			taken_q[wr_idx]  <= upd_taken;
		end
	end

endmodule : btb

`default_nettype wire

/* hw/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    advance,        // response accepted
	input  logic                    redirect_valid, // flush from execute
	input  lc3b_isa_pkg::lc3b_word  redirect_pc,

	input  logic                    pred_use,       // btb hit and taken
	input  lc3b_isa_pkg::lc3b_word  pred_target,

	output lc3b_isa_pkg::lc3b_word  pc
);

	lc3b_isa_pkg::lc3b_word pc_q;
	lc3b_isa_pkg::lc3b_word pc_d;
	lc3b_isa_pkg::lc3b_word pc_plus2;

	assign pc_plus2 = pc_q + 16'd2; // sequential path

	// next pc select, redirect wins over everything
	always_comb begin
		pc_d = pc_q; // hold while waiting or stalled
		if (redirect_valid) begin
			pc_d = redirect_pc;
		end else if (advance) begin
			if (pred_use) begin
				pc_d = pred_target; // follow the prediction
			end else begin
				pc_d = pc_plus2;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= fetch_pkg::RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	assign pc = pc_q;

endmodule : pc_unit

`default_nettype wire

/* hw/ipacket_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ipacket_gen (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    load,  // capture this cycle
	input  logic                    flush, // drop pending entry
	input  lc3b_isa_pkg::lc3b_word  pc,
	input  lc3b_isa_pkg::lc3b_word  inst,
	input  logic                    pred_taken,
	input  lc3b_isa_pkg::lc3b_word  pred_target,
	output logic                    full,

	// to decode
	output logic                    pkt_valid,
	input  logic                    pkt_ready,
	output lc3b_isa_pkg::lc3b_word  pkt_pc,
	output lc3b_isa_pkg::lc3b_word  pkt_inst,
	output logic                    pkt_branch,
	output logic                    pkt_pred_taken,
	output lc3b_isa_pkg::lc3b_word  pkt_pred_target
);

	lc3b_isa_pkg::lc3b_opcode_e opcode;
	logic                       is_branch;

	logic                   valid_q;
	lc3b_isa_pkg::lc3b_word pc_q;
	lc3b_isa_pkg::lc3b_word inst_q;
	logic                   branch_q;
	logic                   pred_taken_q;
	lc3b_isa_pkg::lc3b_word pred_target_q;

	assign opcode    = lc3b_isa_pkg::lc3b_opcode_e'(inst[15 -: lc3b_isa_pkg::OPC_WIDTH]);
	assign is_branch = lc3b_isa_pkg::is_ctrl_flow(opcode); // br/jmp/jsr/trap/rti

	// occupancy, flush beats a same cycle load
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (pkt_ready) begin
			valid_q <= 1'b0; // handed to decode
		end
	end

	// payload only moves on load, so it is stable while held
	always_ff @(posedge clk) begin
		if (load) begin
			pc_q          <= pc;
			inst_q        <= inst;
			branch_q      <= is_branch;
			pred_taken_q  <= pred_taken;
			pred_target_q <= pred_target;
		end
	end

	assign full            = valid_q;
	assign pkt_valid       = valid_q;
	assign pkt_pc          = pc_q;
	assign pkt_inst        = inst_q;
	assign pkt_branch      = branch_q;
	assign pkt_pred_taken  = pred_taken_q;
	assign pkt_pred_target = pred_target_q;

endmodule : ipacket_gen

`default_nettype wire

/* hw/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module if_stage (
	input  logic                    clk,
	input  logic                    rst_n,

	// instruction memory
	output logic                    imem_req_valid,
	input  logic                    imem_req_ready,
	output lc3b_isa_pkg::lc3b_word  imem_req_addr,
	input  logic                    imem_rsp_valid,
	input  lc3b_isa_pkg::lc3b_word  imem_rsp_data,

	// flush from execute
	input  logic                    redirect_valid,
	input  lc3b_isa_pkg::lc3b_word  redirect_pc,

	// btb lookup
	output lc3b_isa_pkg::lc3b_word  lookup_pc,
	input  logic                    btb_hit,
	input  logic                    btb_pred_taken,
	input  lc3b_isa_pkg::lc3b_word  btb_pred_target,

	// packet to decode
	output logic                    pkt_valid,
	input  logic                    pkt_ready,
	output lc3b_isa_pkg::lc3b_word  pkt_pc,
	output lc3b_isa_pkg::lc3b_word  pkt_inst,
	output logic                    pkt_branch,
	output logic                    pkt_pred_taken,
	output lc3b_isa_pkg::lc3b_word  pkt_pred_target
);

	fetch_pkg::fetch_state_e state_q;
	fetch_pkg::fetch_state_e state_d;

	lc3b_isa_pkg::lc3b_word pc;
	logic                   pkt_full;
	logic                   req_fire;
	logic                   rsp_take;  // good response, becomes a packet
	logic                   pred_use;

	// no request while decode holds a packet
	assign imem_req_valid = (state_q == fetch_pkg::F_REQ) && (!pkt_full || pkt_ready);
	assign imem_req_addr  = pc;
	assign req_fire       = imem_req_valid && imem_req_ready;

	assign rsp_take = (state_q == fetch_pkg::F_WAIT) && imem_rsp_valid && !redirect_valid;
	assign lookup_pc = pc; // pc holds the fetched address until the response
	assign pred_use  = btb_hit && btb_pred_taken;

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::F_REQ: begin
				if (req_fire) begin
					// a request leaving with a redirect is already stale
					state_d = redirect_valid ? fetch_pkg::F_DROP : fetch_pkg::F_WAIT;
				end
			end
			fetch_pkg::F_WAIT: begin
				if (imem_rsp_valid) begin
					state_d = fetch_pkg::F_REQ; // taken or discarded
				end else if (redirect_valid) begin
					state_d = fetch_pkg::F_DROP;
				end
			end
			fetch_pkg::F_DROP: begin
				if (imem_rsp_valid) begin
					state_d = fetch_pkg::F_REQ; // stale word thrown away
				end
			end
			default: begin
				state_d = fetch_pkg::F_REQ;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= fetch_pkg::F_REQ;
		end else begin
			state_q <= state_d;
		end
	end

	pc_unit i_pc_unit (
		.clk            (clk),
		.rst_n          (rst_n),
		.advance        (rsp_take),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.pred_use       (pred_use),
		.pred_target    (btb_pred_target),
		.pc             (pc)
	);

	ipacket_gen i_ipacket_gen (
		.clk             (clk),
		.rst_n           (rst_n),
		.load            (rsp_take),
		.flush           (redirect_valid),
		.pc              (pc),
		.inst            (imem_rsp_data),
		.pred_taken      (pred_use),
		.pred_target     (btb_pred_target),
		.full            (pkt_full),
		.pkt_valid       (pkt_valid),
		.pkt_ready       (pkt_ready),
		.pkt_pc          (pkt_pc),
		.pkt_inst        (pkt_inst),
		.pkt_branch      (pkt_branch),
		.pkt_pred_taken  (pkt_pred_taken),
		.pkt_pred_target (pkt_pred_target)
	);

endmodule : if_stage

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  logic                    clk,
	input  logic                    rst_n,

	output logic                    imem_req_valid,
	input  logic                    imem_req_ready,
	output lc3b_isa_pkg::lc3b_word  imem_req_addr,
	input  logic                    imem_rsp_valid,
	input  lc3b_isa_pkg::lc3b_word  imem_rsp_data,

	input  logic                    redirect_valid, // one cycle pulse
	input  lc3b_isa_pkg::lc3b_word  redirect_pc,

	input  logic                    upd_valid,      // btb training
	input  lc3b_isa_pkg::lc3b_word  upd_pc,
	input  lc3b_isa_pkg::lc3b_word  upd_target,
	input  logic                    upd_taken,

	output logic                    pkt_valid,
	input  logic                    pkt_ready,
	output lc3b_isa_pkg::lc3b_word  pkt_pc,
	output lc3b_isa_pkg::lc3b_word  pkt_inst,
	output logic                    pkt_branch,
	output logic                    pkt_pred_taken,
	output lc3b_isa_pkg::lc3b_word  pkt_pred_target
);

	lc3b_isa_pkg::lc3b_word lookup_pc;
	logic                   btb_hit;
	logic                   btb_pred_taken;
	lc3b_isa_pkg::lc3b_word btb_pred_target;

	if_stage i_if_stage (
		.clk             (clk),
		.rst_n           (rst_n),
		.imem_req_valid  (imem_req_valid),
		.imem_req_ready  (imem_req_ready),
		.imem_req_addr   (imem_req_addr),
		.imem_rsp_valid  (imem_rsp_valid),
		.imem_rsp_data   (imem_rsp_data),
		.redirect_valid  (redirect_valid),
		.redirect_pc     (redirect_pc),
		.lookup_pc       (lookup_pc),
		.btb_hit         (btb_hit),
		.btb_pred_taken  (btb_pred_taken),
		.btb_pred_target (btb_pred_target),
		.pkt_valid       (pkt_valid),
		.pkt_ready       (pkt_ready),
		.pkt_pc          (pkt_pc),
		.pkt_inst        (pkt_inst),
		.pkt_branch      (pkt_branch),
		.pkt_pred_taken  (pkt_pred_taken),
		.pkt_pred_target (pkt_pred_target)
	);

	btb i_btb (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_pc   (lookup_pc),
		.hit         (btb_hit),
		.pred_taken  (btb_pred_taken),
		.pred_target (btb_pred_target),
		.upd_valid   (upd_valid),
		.upd_pc      (upd_pc),
		.upd_target  (upd_target),
		.upd_taken   (upd_taken)
	);

endmodule : fetch_top

`default_nettype wire

/* bench/fetch_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_clkgen #(
	parameter int PERIOD     = 40, // ns
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release just after an edge, away from the sampling point
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule : fetch_clkgen

`default_nettype wire

/* bench/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS  = 5;
	localparam int N          = fetch_pkg::BTB_ENTRIES;

	logic clk;
	logic rst_n;
	logic imem_req_valid;
	logic imem_req_ready = 1'b0; // memory model owns these
	lc3b_isa_pkg::lc3b_word imem_req_addr;
	logic imem_rsp_valid = 1'b0;
	lc3b_isa_pkg::lc3b_word imem_rsp_data = '0;
	logic redirect_valid;
	lc3b_isa_pkg::lc3b_word redirect_pc;
	logic upd_valid;
	lc3b_isa_pkg::lc3b_word upd_pc;
	lc3b_isa_pkg::lc3b_word upd_target;
	logic upd_taken;
	logic pkt_valid;
	logic pkt_ready;
	lc3b_isa_pkg::lc3b_word pkt_pc;
	lc3b_isa_pkg::lc3b_word pkt_inst;
	logic pkt_branch;
	logic pkt_pred_taken;
	lc3b_isa_pkg::lc3b_word pkt_pred_target;

	integer seed = 32'h885132f3;
	int err_count = 0;
	int pass_count = 0;
	lc3b_isa_pkg::lc3b_word br_addr [$]; // addresses that hold a BR word

	// reference btb, written only by btb_write
	logic bt_valid [N] = '{default: 1'b0};
	logic bt_taken [N] = '{default: 1'b0};
	lc3b_isa_pkg::lc3b_word bt_pc [N] = '{default: '0};
	lc3b_isa_pkg::lc3b_word bt_target [N] = '{default: '0};

	// reference fetch stream
	lc3b_isa_pkg::lc3b_word model_pc = fetch_pkg::RESET_PC;
	lc3b_isa_pkg::lc3b_word held_pc;
	lc3b_isa_pkg::lc3b_word exp_inst;
	logic [3:0] idx;
	logic exp_taken;
	logic seen = 1'b0; // current packet already checked
	int n_pkts = 0;
	int n_branch = 0;
	int n_pred = 0;

	// memory model state
	logic mem_fire;
	logic mem_busy = 1'b0;
	lc3b_isa_pkg::lc3b_word fire_addr;
	lc3b_isa_pkg::lc3b_word mem_addr;
	int mem_left;
	integer rnd;

	fetch_clkgen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(4)) i_clkgen (.clk(clk), .rst_n(rst_n));

	fetch_top i_dut (.*);

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			err_count++;
			$display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
		end else begin
			pass_count++;
		end
	endtask

	function automatic logic ctrl_flow(input logic [3:0] opc);
		return opc inside {lc3b_isa_pkg::OP_BR, lc3b_isa_pkg::OP_JMP, lc3b_isa_pkg::OP_JSR,
			lc3b_isa_pkg::OP_TRAP, lc3b_isa_pkg::OP_RTI};
	endfunction

	function automatic lc3b_isa_pkg::lc3b_word mem_word(input lc3b_isa_pkg::lc3b_word addr);
		logic is_br;
		is_br = 1'b0;
		foreach (br_addr[i]) begin
			if (br_addr[i] == addr) is_br = 1'b1;
		end
		return is_br ? {4'h0, 3'b111, addr[9:1]} : (16'hA5A5 ^ addr); // brnzp or fill
	endfunction

	// one read at a time, 1 to 3 cycles latency
	always @(posedge clk) begin
		mem_fire = rst_n && imem_req_valid && imem_req_ready;
		fire_addr = imem_req_addr; // before pc moves
		#1;
		imem_rsp_valid = 1'b0;
		rnd = $random(seed);
		imem_req_ready = rnd[0];
		if (mem_fire) begin
			mem_busy = 1'b1;
			mem_addr = fire_addr;
			mem_left = 1 + ($unsigned($random(seed)) % 3);
		end
		if (mem_busy) begin
			mem_left--;
			if (mem_left == 0) begin
				imem_rsp_valid = 1'b1;
				imem_rsp_data = mem_word(mem_addr);
				mem_busy = 1'b0;
			end
		end
	end

	// decode side reference, checks each packet when it first shows up
	always @(posedge clk) begin
		if (!rst_n) begin
			model_pc = fetch_pkg::RESET_PC;
			seen = 1'b0;
		end else if (redirect_valid) begin
			model_pc = redirect_pc; // pending packet flushed
			seen = 1'b0;
		end else begin
			if (pkt_valid && !seen) begin
				idx = model_pc[4:1];
				exp_inst = mem_word(model_pc);
				exp_taken = bt_valid[idx] && bt_taken[idx] && (bt_pc[idx][15:1] == model_pc[15:1]);
				compare("pkt_pc", model_pc, pkt_pc);
				compare("pkt_inst", exp_inst, pkt_inst);
				compare("pkt_branch", 16'(ctrl_flow(exp_inst[15:12])), 16'(pkt_branch));
				compare("pkt_pred_taken", 16'(exp_taken), 16'(pkt_pred_taken));
				if (exp_taken) compare("pkt_pred_target", bt_target[idx], pkt_pred_target);
				if (pkt_branch) n_branch++;
				if (pkt_pred_taken) n_pred++;
				held_pc = model_pc;
				model_pc = exp_taken ? bt_target[idx] : model_pc + 16'd2;
				seen = 1'b1;
			end else if (pkt_valid) begin
				compare("pkt_pc", held_pc, pkt_pc); // must not move while held
			end
			if (pkt_valid && !pkt_ready) compare("imem_req_valid", 16'h0, 16'(imem_req_valid));
			if (pkt_valid && pkt_ready) begin
				seen = 1'b0;
				n_pkts++;
			end
		end
	end

	task automatic wait_packets(input int n);
		int target;
		target = n_pkts + n;
		while (n_pkts < target) @(negedge clk);
	endtask

	// stall decode until a packet sits in the register, fetch is then idle
	task automatic hold_fetch;
		@(posedge clk);
		#1 pkt_ready = 1'b0;
		do @(posedge clk); while (!pkt_valid);
		#1;
	endtask

	task automatic btb_write(input lc3b_isa_pkg::lc3b_word pc, input lc3b_isa_pkg::lc3b_word tgt,
		input logic tkn);
		upd_valid = 1'b1;
		upd_pc = pc;
		upd_target = tgt;
		upd_taken = tkn;
		@(posedge clk);
		#1 upd_valid = 1'b0;
		bt_valid[pc[4:1]] = 1'b1; // same write, reference copy
		bt_pc[pc[4:1]] = pc;
		bt_target[pc[4:1]] = tgt;
		bt_taken[pc[4:1]] = tkn;
	endtask

	task automatic report_test(input string name, input int e0);
		$display("%s done, %0d errors", name, err_count - e0);
	endtask

	task automatic reset_test;
		int e0;
		e0 = err_count;
		@(posedge rst_n);
		@(posedge clk);
		compare("pkt_valid", 16'h0, 16'(pkt_valid));
		compare("imem_req_valid", 16'h1, 16'(imem_req_valid));
		compare("imem_req_addr", fetch_pkg::RESET_PC, imem_req_addr);
		wait_packets(9);
		compare("branch packets", 16'h0, 16'(n_branch)); // plain alu/load words only
		report_test("reset_test", e0);
	endtask

	task automatic branch_flag_test;
		int e0;
		int b0;
		e0 = err_count;
		b0 = n_branch;
		hold_fetch;
		br_addr.push_back(model_pc + 16'd2);
		br_addr.push_back(model_pc + 16'd6);
		pkt_ready = 1'b1;
		wait_packets(6);
		compare("branch packets", 16'h2, 16'(n_branch - b0));
		report_test("branch_flag_test", e0);
	endtask

	task automatic btb_predict_test;
		int e0;
		int p0;
		lc3b_isa_pkg::lc3b_word b;
		e0 = err_count;
		p0 = n_pred;
		hold_fetch;
		b = model_pc + 16'd6;
		br_addr.push_back(b);
		btb_write(b, b - 16'd4, 1'b1); // three word loop
		pkt_ready = 1'b1;
		while (n_pred - p0 < 3) @(negedge clk);
		hold_fetch;
		btb_write(b, b - 16'd4, 1'b0); // falls out of the loop
		p0 = n_pred;
		pkt_ready = 1'b1;
		wait_packets(8);
		compare("predicted packets", 16'h0, 16'(n_pred - p0));
		report_test("btb_predict_test", e0);
	endtask

	task automatic redirect_test;
		int e0;
		e0 = err_count;
		do @(posedge clk); while (!(imem_req_valid && imem_req_ready)); // read now in flight
		#1 pkt_ready = 1'b0;
		redirect_pc = 16'h0400;
		redirect_valid = 1'b1;
		@(posedge clk);
		#1 redirect_valid = 1'b0;
		pkt_ready = 1'b1;
		do @(posedge clk); while (!pkt_valid);
		compare("pkt_pc", 16'h0400, pkt_pc);
		wait_packets(2);
		hold_fetch; // now flush a pending packet
		redirect_pc = 16'h0500;
		redirect_valid = 1'b1;
		@(posedge clk);
		#1 redirect_valid = 1'b0;
		@(posedge clk);
		compare("pkt_valid", 16'h0, 16'(pkt_valid));
		#1 pkt_ready = 1'b1;
		do @(posedge clk); while (!pkt_valid);
		compare("pkt_pc", 16'h0500, pkt_pc);
		wait_packets(2);
		report_test("redirect_test", e0);
	endtask

	task automatic backpressure_test;
		int e0;
		int span;
		lc3b_isa_pkg::lc3b_word pc0;
		lc3b_isa_pkg::lc3b_word inst0;
		e0 = err_count;
		for (int k = 0; k < 3; k++) begin
			span = 2 + ($unsigned($random(seed)) % 6);
			hold_fetch;
			pc0 = pkt_pc;
			inst0 = pkt_inst;
			repeat (span) begin
				@(posedge clk);
				compare("pkt_valid", 16'h1, 16'(pkt_valid));
				compare("pkt_pc", pc0, pkt_pc);
				compare("pkt_inst", inst0, pkt_inst);
				compare("imem_req_valid", 16'h0, 16'(imem_req_valid));
			end
			#1 pkt_ready = 1'b1;
			wait_packets(3); // order checked by the reference stream
		end
		report_test("backpressure_test", e0);
	endtask

	initial begin
		pkt_ready = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		upd_valid = 1'b0;
		upd_pc = '0;
		upd_target = '0;
		upd_taken = 1'b0;
		reset_test();
		branch_flag_test();
		btb_predict_test();
		redirect_test();
		backpressure_test();
		$display("checks passed: %0d, errors: %0d", pass_count, err_count);
		if (err_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// 2000 cycles per test
	initial begin
		#(NUM_TESTS * 2000 * CLK_PERIOD);
		$display("run timed out, fetch stopped making progress");
		$display("*** FAILED ***");
		$finish;
	end

endmodule : fetch_tb

`default_nettype wire

/* list.f */
hw/lc3b_isa_pkg.sv
hw/fetch_pkg.sv
hw/btb.sv
hw/pc_unit.sv
hw/ipacket_gen.sv
hw/if_stage.sv
hw/fetch_top.sv
bench/fetch_clkgen.sv
bench/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
